// File: bench/tb_harness_model.svh
// Reference model for the harness bench; L2 reads are only issued for words whose four bytes are known
`ifndef TB_HARNESS_MODEL_SVH
`define TB_HARNESS_MODEL_SVH

int unsigned lcg_state = 32'd56350; // Stimulus seed

data_t    model_mem   [L2_WORDS];
bit [3:0] model_known [L2_WORDS]; // Bytes written so far
bit       model_eoc;
data_t    model_code = '0;
int       model_con_cnt;          // Console pulses due

// Expected responses, one entry per issued request
int unsigned exp_cyc_q[$];   // Issue cycle, for the latency check
data_t       exp_rdata_q[$];
bit          exp_err_q[$];
bit          exp_con_q[$];   // Console pulse due with this response
char_t       exp_char_q[$];
bit          exp_eoc_q[$];
data_t       exp_code_q[$];

function automatic int unsigned lcg_next();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state >> 16; // Upper half, low bits repeat too soon
endfunction

function automatic int unsigned rand_below(int unsigned n);
  return lcg_next() % n;
endfunction

function automatic data_t rand32();
  data_t hi;
  data_t lo;
  hi = lcg_next(); // Upper half drawn first
  lo = lcg_next();
  return {hi[15:0], lo[15:0]};
endfunction

// Address map as seen by the requester
function automatic region_t region_of(addr_t addr);
  if (addr >= L2_BASE && addr < L2_BASE + addr_t'(4 * L2_WORDS)) return REGION_L2;
  if (addr == EXIT_ADDR) return REGION_EXIT;
  if (addr == CONSOLE_ADDR) return REGION_CONSOLE;
  return REGION_NONE;
endfunction

// Applies one request to the model at issue time and queues its response
function automatic void predict_response(bit we, addr_t addr, data_t wdata, strb_t be,
                                         int unsigned issue_cyc);
  region_t rgn;
  l2_idx_t idx;
  bit      err;
  bit      con;
  data_t   rdata;
  rgn   = region_of(addr);
  idx   = l2_idx_t'((addr - L2_BASE) >> 2);
  rdata = '0;
  con   = 1'b0;
  err   = (addr[1:0] != 2'b00) || (rgn == REGION_NONE) || (we && model_eoc);
  if (!err && rgn == REGION_L2 && we) begin
    for (int b = 0; b < 4; b++) begin
      if (be[b]) model_mem[idx][8*b +: 8] = wdata[8*b +: 8];
    end
    model_known[idx] |= be;
  end else if (!err && rgn == REGION_L2) begin
    rdata = model_mem[idx];
  end else if (!err && rgn == REGION_EXIT) begin
    if (we) begin
      model_code = wdata;     // Whole word, enables ignored
      model_eoc  = 1'b1;
    end else begin
      rdata = model_code;
    end
  end else if (!err && rgn == REGION_CONSOLE && we && be[0]) begin
    con = 1'b1;
    model_con_cnt++;
  end
  exp_cyc_q.push_back(issue_cyc);
  exp_rdata_q.push_back(rdata);
  exp_err_q.push_back(err);
  exp_con_q.push_back(con);
  exp_char_q.push_back(wdata[7:0]);
  exp_eoc_q.push_back(model_eoc);   // Already set for the exit write itself
  exp_code_q.push_back(model_code);
endfunction

`endif

// File: bench/tb_tile_harness.sv
// Random-traffic testbench for tile_harness; one exit write mid-run, L2 traffic on 128 spread words
`timescale 1ns/1ps
`default_nettype none

module tb_tile_harness
  import harness_types_pkg::*;
  import harness_map_pkg::*;
();

  localparam int N_PRE       = 300;                // Slots before the exit write
  localparam int N_POST      = 100;
  localparam int TOTAL_SLOTS = N_PRE + 4 + N_POST; // Exit write, two writes, one read
  localparam int RUN_NS      = (TOTAL_SLOTS + 100) * 10;

  logic        clk = 1'b0;
  logic        arst_n_i;
  logic        req_valid_i;
  logic        req_we_i;
  addr_t       req_addr_i;
  data_t       req_wdata_i;
  strb_t       req_be_i;
  logic        rsp_valid_o;
  data_t       rsp_rdata_o;
  logic        rsp_err_o;
  logic        eoc_o;
  data_t       exit_code_o;
  logic        console_valid_o;
  char_t       console_char_o;
  int unsigned cyc = 0;  // Rising edges seen
  int          check_cnt = 0;
  int          mismatch_cnt = 0;
  int          other_cnt = 0;
  int          con_seen = 0;

  `include "tb_harness_model.svh"

  tile_harness UUT (.*);

  always #5 clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1;

  task automatic compare(input string name, input data_t got, input data_t exp);
    check_cnt++;
    assert (got === exp) else begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  // One request slot, driven just after the edge
  task automatic drive_slot(input bit valid, input bit we, input addr_t addr,
                            input data_t wdata, input strb_t be);
    @(posedge clk);
    #1;
    req_valid_i = valid;
    req_we_i    = we;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    req_be_i    = be;
    if (valid) predict_response(we, addr, wdata, be, cyc);
  endtask

  // Random slot over L2, mailbox, unmapped, misaligned or idle
  task automatic gen_slot(input bit post_exit);
    int unsigned kind;
    int unsigned idx;
    bit          we;
    addr_t       addr;
    strb_t       be;
    kind = rand_below(16);
    idx  = rand_below(128);
    idx  = idx * 8 + idx % 8;                     // Reaches words 0 and 1023
    addr = L2_BASE + addr_t'(4 * idx);
    we   = rand_below(2);
    be   = rand_below(16);
    if (kind < 6) begin
      we = 1'b1;
    end else if (kind < 10) begin
      we = (model_known[idx] != 4'hF);            // Unknown word gets written first
      if (we) be = 4'hF;
    end else if (kind < 12) begin
      addr = rand_below(2) ? EXIT_ADDR : CONSOLE_ADDR;
      we   = (kind == 10);
      if (we && !post_exit) addr = CONSOLE_ADDR;  // Exit write only once before
    end else if (kind == 12) begin
      case (rand_below(4))
        0:       addr = L2_BASE - 4;
        1:       addr = L2_BASE + addr_t'(4 * L2_WORDS);
        2:       addr = CONSOLE_ADDR + 4;
        default: addr = rand32() & 32'h0FFF_FFFC;
      endcase
    end else if (kind == 13) begin
      addr = (rand_below(2) ? addr : EXIT_ADDR) + 1 + rand_below(3);
    end
    drive_slot(kind < 14, we, addr, rand32(), be);
  endtask

  task automatic check_rsp();
    bit    con;
    char_t ch;
    assert (exp_cyc_q.size() != 0) else begin
      $display("Response arrived with no request outstanding");
      other_cnt++;
    end
    if (exp_cyc_q.size() != 0) begin
      compare("response latency", cyc - exp_cyc_q.pop_front(), 2);
      compare("rsp_rdata_o", rsp_rdata_o, exp_rdata_q.pop_front());
      compare("rsp_err_o", rsp_err_o, exp_err_q.pop_front());
      compare("eoc_o", eoc_o, exp_eoc_q.pop_front());
      compare("exit_code_o", exit_code_o, exp_code_q.pop_front());
      con = exp_con_q.pop_front();
      ch  = exp_char_q.pop_front();
      compare("console_valid_o", console_valid_o, con);
      if (con) compare("console_char_o", console_char_o, ch);
    end
  endtask

  // Outputs sampled mid-cycle
  always @(negedge clk) begin
    if (arst_n_i) begin
      if (console_valid_o === 1'b1) con_seen++;
      if (rsp_valid_o === 1'b1) begin
        check_rsp();
      end else begin
        assert (console_valid_o === 1'b0) else begin
          $display("Console pulse appeared without a response");
          other_cnt++;
        end
      end
    end
  end

  initial begin : watchdog
    #(RUN_NS);
    $display("Timeout, the run did not finish in %0d ns", RUN_NS);
    $display("Testbench failed");
    $finish;
  end

  initial begin : stimulus
    data_t code;
    arst_n_i    = 1'b0;
    req_valid_i = 1'b0;
    req_we_i    = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    req_be_i    = '0;
    repeat (8) @(posedge clk);
    #1 arst_n_i = 1'b1;
    compare("rsp_valid_o", rsp_valid_o, 0);         // Reset state
    compare("console_valid_o", console_valid_o, 0);
    compare("eoc_o", eoc_o, 0);
    compare("exit_code_o", exit_code_o, 0);
    repeat (N_PRE) gen_slot(1'b0);
    code = rand32();
    drive_slot(1'b1, 1'b1, EXIT_ADDR, code, rand_below(16));
    drive_slot(1'b1, 1'b1, L2_BASE, ~code, 4'hF);      // Right behind exit, rejected
    drive_slot(1'b1, 1'b1, CONSOLE_ADDR, code, 4'hF);  // No pulse expected
    drive_slot(1'b1, 1'b0, EXIT_ADDR, '0, 4'hF);
    repeat (N_POST) gen_slot(1'b1);
    drive_slot(1'b0, 1'b0, '0, '0, '0);
    while (exp_cyc_q.size() != 0) @(negedge clk);
    repeat (3) @(negedge clk);                         // Catch extra responses
    compare("console_valid_o pulse count", con_seen, model_con_cnt);
    compare("eoc_o", eoc_o, 1);
    compare("exit_code_o", exit_code_o, model_code);
    $display("Summary: %0d checks, %0d mismatches, %0d other errors",
             check_cnt, mismatch_cnt, other_cnt);
    if (mismatch_cnt + other_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule : tb_tile_harness

`default_nettype wire

// File: design/bus_decode_stage.sv
// Stage 1 of the harness; single-word accesses only, misaligned and unmapped addresses get an error
`timescale 1ns/1ps
`default_nettype none

module bus_decode_stage
  import harness_types_pkg::*;
  import harness_map_pkg::*;
(
  input  wire              clk,
  input  wire              arst_n_i,
  input  wire              req_valid_i,
  input  wire              req_we_i,
  input  wire addr_t       req_addr_i,
  input  wire data_t       req_wdata_i,
  input  wire strb_t       req_be_i,
  input  wire              exit_pending_i, // Exit write seen, later writes rejected
  output logic             s1_valid_o,
  output logic             s1_we_o,
  output region_t          s1_region_o,
  output l2_idx_t          s1_idx_o,
  output data_t            s1_wdata_o,
  output strb_t            s1_be_o,
  output logic             s2_valid_o,
  output region_t          s2_region_o,
  output logic             s2_err_o
);

  addr_t   l2_off;     // Offset from L2 base, wraps below the base
  region_t region_d;
  logic    misaligned;
  logic    req_err;
  logic    s1_err;

  assign l2_off = req_addr_i - L2_BASE;

  // Address classification
  always_comb begin
    region_d = REGION_NONE;
    if (l2_off < addr_t'(L2_WORDS * 4)) begin
      region_d = REGION_L2;
    end else if (req_addr_i == EXIT_ADDR) begin
      region_d = REGION_EXIT;
    end else if (req_addr_i == CONSOLE_ADDR) begin
      region_d = REGION_CONSOLE;
    end
  end

  assign misaligned = |req_addr_i[1:0];
  // Unmapped, misaligned, or a write after the exit write
  assign req_err    = misaligned || (region_d == REGION_NONE) || (req_we_i && exit_pending_i);

  // Control flops, s1 then s2 copy for the merge
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s1_valid_o  <= 1'b0;
      s1_we_o     <= 1'b0;
      s1_region_o <= REGION_NONE;
      s1_err      <= 1'b0;
      s2_valid_o  <= 1'b0;
      s2_region_o <= REGION_NONE;
      s2_err_o    <= 1'b0;
    end else begin
      s1_valid_o  <= req_valid_i;
      s1_we_o     <= req_valid_i && req_we_i;
      s1_region_o <= (req_valid_i && !req_err) ? region_d : REGION_NONE; // Error kills target
      s1_err      <= req_valid_i && req_err;
      s2_valid_o  <= s1_valid_o;
      s2_region_o <= s1_region_o;
      s2_err_o    <= s1_err;
    end
  end

  // Payload, only loaded with a request
  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      s1_idx_o   <= l2_off[L2_IDX_W+1:2]; // Word index in the window
      s1_wdata_o <= req_wdata_i;
      s1_be_o    <= req_be_i;
    end
  end

  // Requester must present clean fields with the strobe
  a_req_known : assert property (@(posedge clk) disable iff (!arst_n_i)
    req_valid_i |-> !$isunknown({req_we_i, req_addr_i, req_wdata_i, req_be_i}));

endmodule : bus_decode_stage

`default_nettype wire

// File: design/harness_map_pkg.sv
// Address map of the harness; L2 base must be aligned to the window size
`default_nettype none

package harness_map_pkg;

  // L2 window, word addressed inside
  localparam logic [31:0] L2_BASE  = 32'h2C00_0000;
  localparam int          L2_WORDS = 1024;          // 4 KiB
  localparam int          L2_IDX_W = 10;            // clog2(L2_WORDS)

  // Word index into the L2 array
  typedef logic [L2_IDX_W-1:0] l2_idx_t;

  // Mailbox registers, exact word addresses only
  localparam logic [31:0] EXIT_ADDR    = 32'h2FFF_0000;
  localparam logic [31:0] CONSOLE_ADDR = 32'h2FFF_0004;

endpackage : harness_map_pkg

`default_nettype wire

// File: design/harness_types_pkg.sv
// Bus-facing types for the harness; 32-bit word bus only, one region code per request
`default_nettype none

package harness_types_pkg;

  // Byte address as seen on the tile data port
  typedef logic [31:0] addr_t;

  // One bus word, no wider accesses
  typedef logic [31:0] data_t;

  // Byte enables, bit b covers data[8*b +: 8]
  typedef logic [3:0] strb_t;

  // Decoded target of a request
  typedef logic [1:0] region_t;

  localparam region_t REGION_NONE    = 2'd0; // Unmapped, or any request flagged as error
  localparam region_t REGION_L2      = 2'd1; // Word memory window
  localparam region_t REGION_EXIT    = 2'd2; // Exit code mailbox
  localparam region_t REGION_CONSOLE = 2'd3; // Character output

  // Console character, byte 0 of the write data
  typedef logic [7:0] char_t;

endpackage : harness_types_pkg

`default_nettype wire

// File: design/l2_store_stage.sv
// Stage 2 word memory; no reset on the array, reading an unwritten word returns X
`timescale 1ns/1ps
`default_nettype none

module l2_store_stage
  import harness_types_pkg::*;
  import harness_map_pkg::*;
(
  input  wire          clk,
  input  wire          s1_valid_i,
  input  wire          s1_we_i,
  input  wire region_t s1_region_i,
  input  wire l2_idx_t s1_idx_i,
  input  wire data_t   s1_wdata_i,
  input  wire strb_t   s1_be_i,
  output data_t        l2_rdata_o
);

  data_t mem [L2_WORDS]; // Word storage
  logic  l2_hit;

  // Region is already NONE on errors, no re-check here
  assign l2_hit = s1_valid_i && (s1_region_i == REGION_L2);

  // Byte-enable write
  always_ff @(posedge clk) begin
    if (l2_hit && s1_we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (s1_be_i[b]) begin
          mem[s1_idx_i][8*b +: 8] <= s1_wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Registered read port, old word on read-during-write
  // Writes return zero so the response carries no stale data
  always_ff @(posedge clk) begin
    if (l2_hit) begin
      if (s1_we_i) begin
        l2_rdata_o <= '0;
      end else begin
        l2_rdata_o <= mem[s1_idx_i];
      end
    end
  end

endmodule : l2_store_stage

`default_nettype wire

// File: design/mailbox_stage.sv
// Stage 2 mailbox; exit is one-shot, console needs byte 0 enabled, exit ignores byte enables
`timescale 1ns/1ps
`default_nettype none

module mailbox_stage
  import harness_types_pkg::*;
(
  input  wire          clk,
  input  wire          arst_n_i,
  input  wire          s1_valid_i,
  input  wire          s1_we_i,
  input  wire region_t s1_region_i,
  input  wire data_t   s1_wdata_i,
  input  wire strb_t   s1_be_i,
  output data_t        mbox_rdata_o,
  output logic         exit_pending_o,
  output logic         eoc_o,
  output data_t        exit_code_o,
  output logic         console_valid_o,
  output char_t        console_char_o
);

  typedef enum logic {
    MBOX_RUN,  // Program running
    MBOX_DONE  // Exit code written, sticky until reset
  } mbox_state_e;

  mbox_state_e state_q, state_d;
  logic        exit_wr;
  logic        console_wr;
  logic        mbox_hit;

  assign exit_wr    = s1_valid_i && s1_we_i && (s1_region_i == REGION_EXIT);
  // No character without byte 0
  assign console_wr = s1_valid_i && s1_we_i && (s1_region_i == REGION_CONSOLE) && s1_be_i[0];
  assign mbox_hit   = s1_valid_i && ((s1_region_i == REGION_EXIT) ||
                                     (s1_region_i == REGION_CONSOLE));

  always_comb begin
    state_d = state_q;
    case (state_q)
      MBOX_RUN:  if (exit_wr) state_d = MBOX_DONE;
      MBOX_DONE: state_d = MBOX_DONE; // Only reset leaves
      default:   state_d = MBOX_RUN;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q         <= MBOX_RUN;
      exit_code_o     <= '0;
      console_valid_o <= 1'b0;
    end else begin
      state_q         <= state_d;
      console_valid_o <= console_wr; // One-cycle strobe
      if (exit_wr) begin
        exit_code_o <= s1_wdata_i; // Full word
      end
    end
  end

  // Character and read data are payload
  always_ff @(posedge clk) begin
    if (console_wr) begin
      console_char_o <= s1_wdata_i[7:0];
    end
    if (mbox_hit) begin
      // Exit read gives the code, console and writes give zero
      mbox_rdata_o <= (!s1_we_i && (s1_region_i == REGION_EXIT)) ? exit_code_o : '0;
    end
  end

  assign eoc_o          = (state_q == MBOX_DONE);
  // Decode sees the exit write already while it sits in s1
  assign exit_pending_o = eoc_o || exit_wr;

  // End of computation is sticky
  a_eoc_sticky : assert property (@(posedge clk) disable iff (!arst_n_i) eoc_o |=> eoc_o);

endmodule : mailbox_stage

`default_nettype wire

// File: design/resp_merge_stage.sv
// Response mux of the harness; combinational, clock and reset only feed the latency check
`timescale 1ns/1ps
`default_nettype none

module resp_merge_stage
  import harness_types_pkg::*;
(
  input  wire          clk,
  input  wire          arst_n_i,
  input  wire          req_valid_i,  // Request strobe, latency check only
  input  wire          s2_valid_i,
  input  wire region_t s2_region_i,
  input  wire          s2_err_i,
  input  wire data_t   l2_rdata_i,
  input  wire data_t   mbox_rdata_i,
  output logic         rsp_valid_o,
  output data_t        rsp_rdata_o,
  output logic         rsp_err_o
);

  logic [1:0] req_hist_q; // Strobe history, bit 1 is two cycles old

  always_comb begin
    case (s2_region_i)
      REGION_L2:      rsp_rdata_o = l2_rdata_i;
      REGION_EXIT,
      REGION_CONSOLE: rsp_rdata_o = mbox_rdata_i;
      default:        rsp_rdata_o = '0; // Errors and unmapped read as zero
    endcase
  end

  assign rsp_valid_o = s2_valid_i;
  assign rsp_err_o   = s2_err_i;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_hist_q <= 2'b00;
    end else begin
      req_hist_q <= {req_hist_q[0], req_valid_i};
    end
  end

  // Fixed two-cycle latency through the whole pipeline
  a_rsp_latency : assert property (@(posedge clk) disable iff (!arst_n_i)
    rsp_valid_o == req_hist_q[1]);

endmodule : resp_merge_stage

`default_nettype wire

// File: design/tile_harness.sv
// Harness top; no back-pressure, every request answered exactly two cycles later
`timescale 1ns/1ps
`default_nettype none

module tile_harness
  import harness_types_pkg::*;
  import harness_map_pkg::*;
(
  input  wire        clk,
  input  wire        arst_n_i,
  input  wire        req_valid_i,
  input  wire        req_we_i,
  input  wire addr_t req_addr_i,
  input  wire data_t req_wdata_i,
  input  wire strb_t req_be_i,
  output logic       rsp_valid_o,
  output data_t      rsp_rdata_o,
  output logic       rsp_err_o,
  output logic       eoc_o,
  output data_t      exit_code_o,
  output logic       console_valid_o,
  output char_t      console_char_o
);

  logic    s1_valid, s1_we;
  region_t s1_region;
  l2_idx_t s1_idx;
  data_t   s1_wdata;
  strb_t   s1_be;
  logic    s2_valid, s2_err;
  region_t s2_region;
  data_t   l2_rdata, mbox_rdata;
  logic    exit_pending; // Mailbox back to decode

  bus_decode_stage u_decode (
    .clk, .arst_n_i,
    .req_valid_i, .req_we_i, .req_addr_i, .req_wdata_i, .req_be_i,
    .exit_pending_i (exit_pending),
    .s1_valid_o     (s1_valid),
    .s1_we_o        (s1_we),
    .s1_region_o    (s1_region),
    .s1_idx_o       (s1_idx),
    .s1_wdata_o     (s1_wdata),
    .s1_be_o        (s1_be),
    .s2_valid_o     (s2_valid),
    .s2_region_o    (s2_region),
    .s2_err_o       (s2_err)
  );

  l2_store_stage u_l2 (
    .clk,
    .s1_valid_i (s1_valid), .s1_we_i (s1_we), .s1_region_i (s1_region),
    .s1_idx_i   (s1_idx), .s1_wdata_i (s1_wdata), .s1_be_i (s1_be),
    .l2_rdata_o (l2_rdata)
  );

  mailbox_stage u_mbox (
    .clk, .arst_n_i,
    .s1_valid_i (s1_valid), .s1_we_i (s1_we), .s1_region_i (s1_region),
    .s1_wdata_i (s1_wdata), .s1_be_i (s1_be),
    .mbox_rdata_o   (mbox_rdata),
    .exit_pending_o (exit_pending),
    .eoc_o, .exit_code_o, .console_valid_o, .console_char_o
  );

  resp_merge_stage u_merge (
    .clk, .arst_n_i, .req_valid_i,
    .s2_valid_i   (s2_valid), .s2_region_i (s2_region), .s2_err_i (s2_err),
    .l2_rdata_i   (l2_rdata),
    .mbox_rdata_i (mbox_rdata),
    .rsp_valid_o, .rsp_rdata_o, .rsp_err_o
  );

endmodule : tile_harness

`default_nettype wire

// File: tile_harness.f
+incdir+bench
design/harness_types_pkg.sv
design/harness_map_pkg.sv
design/bus_decode_stage.sv
design/l2_store_stage.sv
design/mailbox_stage.sv
design/resp_merge_stage.sv
design/tile_harness.sv
bench/tb_tile_harness.sv
